/* verilog/cad_cfg.svh */
// CAD engine configuration
`ifndef CAD_CFG_SVH
`define CAD_CFG_SVH

// Matrix geometry
`define CAD_IMG_SIDE 8
`define CAD_KER_SIDE 5

// Bank contents per load
`define CAD_IMG_NUM  4
`define CAD_KER_NUM  4
`define CAD_ROUNDS   2

// Result width, wide enough for 25 full-scale products
`define CAD_SUM_W    20

// Bank address widths
`define CAD_IMG_AW   8
`define CAD_KER_AW   7

`endif

/* verilog/cad_pkg.sv */
// CAD shared types
`default_nettype none

`include "cad_cfg.svh"

package cad_pkg;

  // Image and kernel element
  typedef logic signed [7:0] pixel_t;

  // Full-precision product of two elements
  typedef logic signed [15:0] product_t;

  // Accumulated convolution sum
  typedef logic signed [`CAD_SUM_W-1:0] conv_sum_t;

  // Controller phases
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOAD,
    ST_WAIT_IDX,
    ST_COMPUTE
  } cad_state_t;

endpackage

`default_nettype wire

/* verilog/matrix_store.sv */
// Matrix register bank
`timescale 1ns/1ps
`default_nettype none

module matrix_store
  import cad_pkg::*;
#(
  parameter int DEPTH = 256,
  parameter int AW    = 8
)
(
  input  logic          clk,
  input  logic          rst_n,
  input  logic          we,
  input  logic [AW-1:0] addr,
  input  pixel_t        wdata,
  output pixel_t        rdata
);

  pixel_t mem [DEPTH];

  // Single port, read data one cycle after the address
  always_ff @(posedge clk)
  begin
    if (we)
      mem[addr] <= wdata;
    rdata <= mem[addr];
  end

  // Load addressing from the controller must stay inside the bank
  a_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
    we |-> addr < DEPTH);

endmodule

`default_nettype wire

/* verilog/cad_ctrl.sv */
// CAD phase controller
`timescale 1ns/1ps
`default_nettype none

`include "cad_cfg.svh"

module cad_ctrl
  import cad_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   in_valid,
  input  logic                   in_valid2,
  input  logic [3:0]             matrix_idx,
  output logic                   img_we,
  output logic                   ker_we,
  output logic [`CAD_IMG_AW-1:0] img_addr,
  output logic [`CAD_KER_AW-1:0] ker_addr,
  output logic                   tap_valid,
  output logic                   tap_first,
  output logic                   tap_last
);

  localparam int IMG_SZ     = `CAD_IMG_SIDE * `CAD_IMG_SIDE;
  localparam int KER_SZ     = `CAD_KER_SIDE * `CAD_KER_SIDE;
  localparam int IMG_BEATS  = `CAD_IMG_NUM * IMG_SZ;
  localparam int LOAD_BEATS = IMG_BEATS + `CAD_KER_NUM * KER_SZ;
  localparam int LW         = $clog2(LOAD_BEATS);
  localparam logic [2:0] KMAX       = 3'(`CAD_KER_SIDE - 1);
  localparam logic [3:0] LAST_ROUND = 4'(`CAD_ROUNDS - 1);

  cad_state_t  state_q;
  logic [LW-1:0] load_cnt;
  logic [LW-1:0] ker_off;
  logic        load_beat;
  logic        load_last;
  logic        idx_second;
  logic [3:0]  img_idx_q;
  logic [3:0]  ker_idx_q;
  logic [3:0]  pos_q;
  logic [2:0]  kx_q;
  logic [2:0]  ky_q;
  logic [3:0]  round_q;
  logic [2:0]  orow;
  logic [2:0]  ocol;
  logic [15:0] img_lin;
  logic [15:0] ker_lin;
  logic        compute;

  // ------------------------------
  // Load routing
  // ------------------------------
  assign compute   = (state_q == ST_COMPUTE);
  assign load_beat = in_valid && (state_q == ST_IDLE || state_q == ST_LOAD);
  assign load_last = load_beat && (load_cnt == LW'(LOAD_BEATS - 1));
  assign img_we    = load_beat && (load_cnt < LW'(IMG_BEATS));
  assign ker_we    = load_beat && !(load_cnt < LW'(IMG_BEATS));
  assign ker_off   = load_cnt - LW'(IMG_BEATS);

  // ------------------------------
  // Compute addressing
  // ------------------------------
  // pos[3:2] picks the pool window, pos[1:0] the cell inside it
  assign orow = {1'b0, pos_q[3], pos_q[1]};
  assign ocol = {1'b0, pos_q[2], pos_q[0]};

  assign img_lin = 16'(img_idx_q) * 16'(IMG_SZ) + 16'(orow + ky_q) * 16'(`CAD_IMG_SIDE)
                 + 16'(ocol + kx_q);
  assign ker_lin = 16'(ker_idx_q) * 16'(KER_SZ) + 16'(ky_q) * 16'(`CAD_KER_SIDE)
                 + 16'(kx_q);

  assign img_addr = compute ? img_lin[`CAD_IMG_AW-1:0] : load_cnt[`CAD_IMG_AW-1:0];
  assign ker_addr = compute ? ker_lin[`CAD_KER_AW-1:0] : ker_off[`CAD_KER_AW-1:0];

  // ------------------------------
  // Phase FSM and counters
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q    <= ST_IDLE;
      load_cnt   <= '0;
      idx_second <= 1'b0;
      img_idx_q  <= '0;
      ker_idx_q  <= '0;
      pos_q      <= '0;
      kx_q       <= '0;
      ky_q       <= '0;
      round_q    <= '0;
    end
    else
    begin
      if (load_beat)
        load_cnt <= load_last ? '0 : load_cnt + 1'b1;
      case (state_q)
        ST_IDLE:
          if (in_valid)
            state_q <= ST_LOAD;
        ST_LOAD:
          if (load_last)
            state_q <= ST_WAIT_IDX;
        ST_WAIT_IDX:
          if (in_valid2)
          begin
            // Image index first, kernel index on the next beat
            if (!idx_second)
              img_idx_q <= matrix_idx;
            else
            begin
              ker_idx_q <= matrix_idx;
              state_q   <= ST_COMPUTE;
            end
            idx_second <= !idx_second;
          end
        default:
          if (kx_q != KMAX)
            kx_q <= kx_q + 1'b1;
          else
          begin
            kx_q <= '0;
            if (ky_q != KMAX)
              ky_q <= ky_q + 1'b1;
            else
            begin
              ky_q  <= '0;
              pos_q <= pos_q + 1'b1;
              if (pos_q == 4'd15)
              begin
                round_q <= (round_q == LAST_ROUND) ? '0 : round_q + 1'b1;
                state_q <= (round_q == LAST_ROUND) ? ST_IDLE : ST_WAIT_IDX;
              end
            end
          end
      endcase
    end
  end

  // Tap flags line up with the store read data
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tap_valid <= 1'b0;
      tap_first <= 1'b0;
      tap_last  <= 1'b0;
    end
    else
    begin
      tap_valid <= compute;
      tap_first <= compute && kx_q == '0 && ky_q == '0;
      tap_last  <= compute && kx_q == KMAX && ky_q == KMAX;
    end
  end

  // Index pairs only while the engine waits for one
  a_idx_phase: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid2 |-> state_q == ST_WAIT_IDX);

endmodule

`default_nettype wire

/* verilog/conv_engine.sv */
// Convolution MAC
`timescale 1ns/1ps
`default_nettype none

module conv_engine
  import cad_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      tap_valid,
  input  logic      tap_first,
  input  logic      tap_last,
  input  pixel_t    img_pixel,
  input  pixel_t    ker_pixel,
  output logic      conv_valid,
  output conv_sum_t conv_sum
);

  product_t  product;
  conv_sum_t acc_q;
  conv_sum_t acc_next;

  // ------------------------------
  // Multiply and accumulate
  // ------------------------------
  assign product = img_pixel * ker_pixel;

  // First tap of a position restarts the sum
  assign acc_next = tap_first ? conv_sum_t'(product) : acc_q + conv_sum_t'(product);

  always_ff @(posedge clk)
  begin
    if (tap_valid)
      acc_q <= acc_next;
  end

  // ------------------------------
  // Result register
  // ------------------------------
  always_ff @(posedge clk)
  begin
    if (tap_valid && tap_last)
      conv_sum <= acc_next;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      conv_valid <= 1'b0;
    else
      conv_valid <= tap_valid && tap_last;
  end

endmodule

`default_nettype wire

/* verilog/pool_serializer.sv */
// Max pool and bit-serial output
`timescale 1ns/1ps
`default_nettype none

`include "cad_cfg.svh"

module pool_serializer
  import cad_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      conv_valid,
  input  conv_sum_t conv_sum,
  output logic      out_valid,
  output logic      out_value
);

  localparam int BW = $clog2(`CAD_SUM_W);
  localparam logic [BW-1:0] LAST_BIT = BW'(`CAD_SUM_W - 1);

  logic [1:0]    grp_cnt;
  conv_sum_t     run_max;
  conv_sum_t     win_max;
  conv_sum_t     shift_q;
  logic          busy;
  logic [BW-1:0] bit_cnt;

  // First sum of a window seeds the maximum
  assign win_max = (grp_cnt == 2'd0 || conv_sum > run_max) ? conv_sum : run_max;

  always_ff @(posedge clk)
  begin
    if (conv_valid)
      run_max <= win_max;
    if (conv_valid && grp_cnt == 2'd3)
      shift_q <= win_max;
    else if (busy)
      shift_q <= shift_q >> 1;
  end

  // ------------------------------
  // Window count and shift control
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      grp_cnt <= '0;
      busy    <= 1'b0;
      bit_cnt <= '0;
    end
    else
    begin
      if (conv_valid)
        grp_cnt <= grp_cnt + 1'b1;
      if (conv_valid && grp_cnt == 2'd3)
      begin
        busy    <= 1'b1;
        bit_cnt <= '0;
      end
      else if (busy)
      begin
        if (bit_cnt == LAST_BIT)
          busy <= 1'b0;
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  // LSB first, quiet between results
  assign out_valid = busy;
  assign out_value = busy & shift_q[0];

  // Windows are spaced far enough apart that a shift always completes
  a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
    conv_valid |-> !busy);

endmodule

`default_nettype wire

/* verilog/cad_top.sv */
// Convolution and max pool engine
`timescale 1ns/1ps
`default_nettype none

`include "cad_cfg.svh"

module cad_top
  import cad_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       in_valid,
  input  logic       in_valid2,
  input  pixel_t     matrix,
  input  logic [3:0] matrix_idx,
  output logic       out_valid,
  output logic       out_value
);

  localparam int IMG_DEPTH = `CAD_IMG_NUM * `CAD_IMG_SIDE * `CAD_IMG_SIDE;
  localparam int KER_DEPTH = `CAD_KER_NUM * `CAD_KER_SIDE * `CAD_KER_SIDE;

  logic                   img_we;
  logic                   ker_we;
  logic [`CAD_IMG_AW-1:0] img_addr;
  logic [`CAD_KER_AW-1:0] ker_addr;
  logic                   tap_valid;
  logic                   tap_first;
  logic                   tap_last;
  pixel_t                 img_pixel;
  pixel_t                 ker_pixel;
  logic                   conv_valid;
  conv_sum_t              conv_sum;

  // ------------------------------
  // Control and storage
  // ------------------------------
  cad_ctrl cad_ctrl_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_valid2  (in_valid2),
    .matrix_idx (matrix_idx),
    .img_we     (img_we),
    .ker_we     (ker_we),
    .img_addr   (img_addr),
    .ker_addr   (ker_addr),
    .tap_valid  (tap_valid),
    .tap_first  (tap_first),
    .tap_last   (tap_last)
  );

  matrix_store #(.DEPTH(IMG_DEPTH), .AW(`CAD_IMG_AW)) img_store (
    .clk   (clk),
    .rst_n (rst_n),
    .we    (img_we),
    .addr  (img_addr),
    .wdata (matrix),
    .rdata (img_pixel)
  );

  matrix_store #(.DEPTH(KER_DEPTH), .AW(`CAD_KER_AW)) ker_store (
    .clk   (clk),
    .rst_n (rst_n),
    .we    (ker_we),
    .addr  (ker_addr),
    .wdata (matrix),
    .rdata (ker_pixel)
  );

  // ------------------------------
  // Datapath
  // ------------------------------
  conv_engine conv_engine_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .tap_valid  (tap_valid),
    .tap_first  (tap_first),
    .tap_last   (tap_last),
    .img_pixel  (img_pixel),
    .ker_pixel  (ker_pixel),
    .conv_valid (conv_valid),
    .conv_sum   (conv_sum)
  );

  pool_serializer pool_serializer_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .conv_valid (conv_valid),
    .conv_sum   (conv_sum),
    .out_valid  (out_valid),
    .out_value  (out_value)
  );

endmodule

`default_nettype wire

/* test/cad_tb.sv */
// CAD engine testbench
`timescale 1ns/1ps
`default_nettype none

`include "cad_cfg.svh"

module cad_tb
  import cad_pkg::*;
();

  localparam int IMG_SZ      = `CAD_IMG_SIDE * `CAD_IMG_SIDE;
  localparam int KER_SZ      = `CAD_KER_SIDE * `CAD_KER_SIDE;
  localparam int LOAD_BEATS  = `CAD_IMG_NUM * IMG_SZ + `CAD_KER_NUM * KER_SZ;
  localparam int TIMEOUT_CYC = 2 * (LOAD_BEATS + `CAD_ROUNDS * 500) + 200;

  logic       clk;
  logic       rst_n;
  logic       in_valid;
  logic       in_valid2;
  pixel_t     matrix;
  logic [3:0] matrix_idx;
  logic       out_valid;
  logic       out_value;

  logic [31:0] rng;
  int          cycle_cnt;
  int          errors;
  int          tests_run;
  int          tests_failed;

  // Host-side copies of the loaded banks
  logic signed [7:0] img_m [`CAD_IMG_NUM][IMG_SZ];
  logic signed [7:0] ker_m [`CAD_KER_NUM][KER_SZ];

  cad_top cad_top_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_valid2  (in_valid2),
    .matrix     (matrix),
    .matrix_idx (matrix_idx),
    .out_valid  (out_valid),
    .out_value  (out_value)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYC)
    begin
      $display("Run timed out after %0d cycles waiting for the DUT", cycle_cnt);
      $display("Test failures found");
      $finish;
    end
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // Max over one 2x2 window of valid 5x5 correlation sums
  function automatic int pool_expect(int ii, int ki, int w);
    int best;
    int sum;
    int r;
    int c;
    best = 0;
    for (int d = 0; d < 4; d++)
    begin
      r = 2 * (w / 2) + d / 2;
      c = 2 * (w % 2) + d % 2;
      sum = 0;
      for (int ky = 0; ky < `CAD_KER_SIDE; ky++)
        for (int kx = 0; kx < `CAD_KER_SIDE; kx++)
          sum += int'(img_m[ii][(r + ky) * `CAD_IMG_SIDE + c + kx])
               * int'(ker_m[ki][ky * `CAD_KER_SIDE + kx]);
      if (d == 0 || sum > best)
        best = sum;
    end
    return best;
  endfunction

  task automatic check_value(input string name, input int expected, input int actual);
    if (expected !== actual)
    begin
      $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before)
      $display("%s: pass", name);
    else
    begin
      $display("%s: fail", name);
      tests_failed++;
    end
  endtask

  // Random banks, or saturated matrices at index 0 and 1
  task automatic fill_matrices(input bit extreme);
    logic [31:0] r;
    for (int m = 0; m < `CAD_IMG_NUM; m++)
      for (int p = 0; p < IMG_SZ; p++)
      begin
        r = next_rand();
        img_m[m][p] = (extreme && m == 0) ? 8'sh80 : (extreme && m == 1) ? 8'sh7f : r[7:0];
      end
    for (int m = 0; m < `CAD_KER_NUM; m++)
      for (int p = 0; p < KER_SZ; p++)
      begin
        r = next_rand();
        ker_m[m][p] = (extreme && m == 0) ? 8'sh80 : (extreme && m == 1) ? 8'sh7f : r[7:0];
      end
  endtask

  task automatic stream_load();
    for (int m = 0; m < `CAD_IMG_NUM; m++)
      for (int p = 0; p < IMG_SZ; p++)
      begin
        @(negedge clk);
        in_valid = 1'b1;
        matrix   = img_m[m][p];
      end
    for (int m = 0; m < `CAD_KER_NUM; m++)
      for (int p = 0; p < KER_SZ; p++)
      begin
        @(negedge clk);
        matrix = ker_m[m][p];
      end
    @(negedge clk);
    in_valid = 1'b0;
    matrix   = '0;
  endtask

  // ------------------------------
  // One round: index pair, 80 result bits, quiet tail
  // ------------------------------
  task automatic run_round(input string name, input int ii, input int ki);
    logic signed [`CAD_SUM_W-1:0] got [4];
    int bits;
    int extra;
    int stray;
    int err_before;
    err_before = errors;
    bits = 0;
    extra = 0;
    stray = 0;
    @(negedge clk);
    in_valid2  = 1'b1;
    matrix_idx = 4'(ii);
    @(negedge clk);
    matrix_idx = 4'(ki);
    @(negedge clk);
    in_valid2  = 1'b0;
    matrix_idx = '0;
    while (bits < 4 * `CAD_SUM_W)
    begin
      @(negedge clk);
      if (out_valid)
      begin
        got[bits / `CAD_SUM_W][bits % `CAD_SUM_W] = out_value;
        bits++;
      end
      else if (out_value)
        stray++;
    end
    repeat (30)
    begin
      @(negedge clk);
      if (out_valid)
        extra++;
      else if (out_value)
        stray++;
    end
    check_value({name, " bit count"}, 4 * `CAD_SUM_W, bits + extra);
    // Data line must stay low between marked bits
    check_value({name, " unmarked value"}, 0, stray);
    for (int w = 0; w < 4; w++)
      check_value($sformatf("%s value %0d", name, w), pool_expect(ii, ki, w), int'(got[w]));
    report_test(name, err_before);
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial
  begin
    int quiet_err;
    int busy_cnt;
    rng          = 32'd67885;
    cycle_cnt    = 0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    rst_n        = 1'b0;
    in_valid     = 1'b0;
    in_valid2    = 1'b0;
    matrix       = '0;
    matrix_idx   = '0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    // Nothing comes out before the first load
    quiet_err = errors;
    busy_cnt  = 0;
    repeat (20)
    begin
      @(negedge clk);
      if (out_valid || out_value)
        busy_cnt++;
    end
    check_value("reset_quiet", 0, busy_cnt);
    report_test("reset_quiet", quiet_err);

    fill_matrices(1'b0);
    stream_load();
    for (int r = 0; r < `CAD_ROUNDS; r++)
      run_round($sformatf("load1_round%0d", r), next_rand() % `CAD_IMG_NUM,
                next_rand() % `CAD_KER_NUM);

    // Second load replaces both banks with saturated data
    fill_matrices(1'b1);
    stream_load();
    for (int r = 0; r < `CAD_ROUNDS; r++)
      run_round($sformatf("load2_round%0d", r), r % 2, 0);

    $display("Tests run: %0d, passed: %0d, failed: %0d", tests_run,
             tests_run - tests_failed, tests_failed);
    if (errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+verilog
verilog/cad_pkg.sv
verilog/matrix_store.sv
verilog/cad_ctrl.sv
verilog/conv_engine.sv
verilog/pool_serializer.sv
verilog/cad_top.sv
test/cad_tb.sv
